// ==== hdl/vit_trb_pkg.sv ====
package vit_trb_pkg;

  //----------------------------------------------------------
  // trellis and frame sizes
  //----------------------------------------------------------

  localparam int cSTATE_NUM  = 8;  // K=4 -> 8 states
  localparam int cSTATE_W    = 3;
  localparam int cUNC_W      = 2;  // uncoded bits per step
  localparam int cFRAME_MAX  = 64; // steps per frame, tail included
  localparam int cFRAME_W    = 6;
  localparam int cRAM_ADDR_W = 7;  // {bank, step index}

  //----------------------------------------------------------
  // bundles
  //----------------------------------------------------------

  // one trellis step from the ACS side
  typedef struct packed {
    logic                  sop;
    logic                  eop;
    logic [cSTATE_NUM-1:0] decision; // survivor bit per state
    logic [cUNC_W-1:0]     unc;
  } trb_step_t;

  typedef struct packed {
    logic [cSTATE_NUM-1:0] decision;
    logic [cUNC_W-1:0]     unc;
  } trb_ram_word_t;

  // traceback request, one per closed bank
  typedef struct packed {
    logic                bank;
    logic [cFRAME_W-1:0] last; // index of final step
  } trb_job_t;

  typedef struct packed {
    logic              dbit; // decoded info bit
    logic [cUNC_W-1:0] unc;
  } trb_lifo_word_t;

  typedef struct packed {
    logic              sop;
    logic              eop;
    logic              dbit;
    logic [cUNC_W-1:0] unc;
  } trb_out_t;

  // state = last three inputs, newest in msb
  // predecessor drops the msb and takes the survivor bit as the new lsb
  function automatic logic [cSTATE_W-1:0] trb_prev_state(
    input logic [cSTATE_W-1:0]   s,
    input logic [cSTATE_NUM-1:0] dec
  );
    return {s[cSTATE_W-2:0], dec[s]};
  endfunction

endpackage

// ==== hdl/vit_trb_ram.sv ====
module vit_trb_ram import vit_trb_pkg::*; (
  input  logic                   iclk,
  input  logic                   wr_en,
  input  logic [cRAM_ADDR_W-1:0] wr_addr,
  input  trb_ram_word_t          wr_data,
  input  logic [cRAM_ADDR_W-1:0] rd_addr,
  output trb_ram_word_t          rd_data
);

  // two banks of cFRAME_MAX steps
  trb_ram_word_t mem [2**cRAM_ADDR_W];

  //----------------------------------------------------------
  // write port
  //----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //----------------------------------------------------------
  // read port, one cycle latency
  //----------------------------------------------------------

  // writer and reader never share a bank, no bypass needed
  always_ff @(posedge iclk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== hdl/vit_trb_ctrl.sv ====
module vit_trb_ctrl import vit_trb_pkg::*; (
  input  logic                   iclk,
  input  logic                   ireset,
  input  trb_step_t              in_step,
  input  logic                   in_valid,
  output logic                   in_ready,
  output logic                   wr_en,
  output logic [cRAM_ADDR_W-1:0] wr_addr,
  output trb_ram_word_t          wr_data,
  output trb_job_t               job,
  output logic                   job_valid,
  input  logic                   job_ready,
  input  logic                   bank_free
);

  logic                cur_bank;   // bank being written
  logic                trace_ptr;  // next bank to hand to the engine
  logic                free_ptr;   // next bank the engine will release
  logic [1:0]          busy;       // frame stored, not yet released
  logic [1:0]          pend;       // job not yet accepted
  logic [cFRAME_W:0]   wr_ptr;     // one spare bit for overrun check
  logic [cFRAME_W:0]   idx;
  logic [cFRAME_W-1:0] last_idx [2];
  logic                frame_open;
  logic                acc;
  logic                job_acc;

  //----------------------------------------------------------
  // write side
  //----------------------------------------------------------

  assign acc      = in_valid & in_ready;
  assign in_ready = ~busy[cur_bank]; // stall only when both banks are full
  assign idx      = in_step.sop ? '0 : wr_ptr; // sop restarts the frame

  assign wr_en            = acc;
  assign wr_addr          = {cur_bank, idx[cFRAME_W-1:0]};
  assign wr_data.decision = in_step.decision;
  assign wr_data.unc      = in_step.unc;

  // banks are traced in the order they were closed
  assign job_acc   = job_valid & job_ready;
  assign job_valid = pend[trace_ptr];
  assign job.bank  = trace_ptr;
  assign job.last  = last_idx[trace_ptr];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cur_bank   <= 1'b0;
      trace_ptr  <= 1'b0;
      free_ptr   <= 1'b0;
      busy       <= '0;
      pend       <= '0;
      wr_ptr     <= '0;
      frame_open <= 1'b0;
    end
    else begin
      if (acc) begin
        wr_ptr     <= idx + 1'b1;
        frame_open <= ~in_step.eop;
        if (in_step.eop) begin
          cur_bank <= ~cur_bank; // flip to the other bank
        end
      end
      if (job_acc) begin
        pend[trace_ptr] <= 1'b0;
        trace_ptr       <= ~trace_ptr;
      end
      if (bank_free) begin
        busy[free_ptr] <= 1'b0;
        free_ptr       <= ~free_ptr;
      end
      // closed bank can't be busy or pending here, in_ready guards it
      if (acc && in_step.eop) begin
        busy[cur_bank] <= 1'b1;
        pend[cur_bank] <= 1'b1; // job shows up next cycle
      end
    end
  end

  // end index per bank
  always_ff @(posedge iclk) begin
    if (acc && in_step.eop) begin
      last_idx[cur_bank] <= idx[cFRAME_W-1:0];
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  a_frame_len : assert property (@(posedge iclk) disable iff (ireset)
    (acc && in_step.eop) |-> (idx < cFRAME_MAX));

  a_sop_first : assert property (@(posedge iclk) disable iff (ireset)
    (acc && !frame_open) |-> in_step.sop);

endmodule

// ==== hdl/vit_trb_engine.sv ====
module vit_trb_engine import vit_trb_pkg::*; (
  input  logic                   iclk,
  input  logic                   ireset,
  input  trb_job_t               job,
  input  logic                   job_valid,
  output logic                   job_ready,
  output logic                   bank_free,
  output logic [cRAM_ADDR_W-1:0] rd_addr,
  input  trb_ram_word_t          rd_data,
  input  logic                   lifo_free,
  output logic                   lifo_wr,
  output logic [cFRAME_W-1:0]    lifo_waddr,
  output trb_lifo_word_t         lifo_wdata,
  output logic                   lifo_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_walk,  // issuing reads, last down to 0
    st_drain  // last word in flight, then done
  } state_t;

  state_t              state;
  logic                bank;
  logic [cFRAME_W-1:0] last;
  logic [cFRAME_W-1:0] rd_idx;     // index being read
  logic                rd_vld;     // rd_data valid this cycle
  logic [cFRAME_W-1:0] rd_vld_idx; // index of rd_data
  logic [cSTATE_W-1:0] trel_state; // survivor path state

  //----------------------------------------------------------
  // outputs
  //----------------------------------------------------------

  assign job_ready = (state == st_idle) & lifo_free;
  assign rd_addr   = {bank, rd_idx};
  assign bank_free = (state == st_walk) & (rd_idx == '0); // word 0 read issued

  assign lifo_wr         = rd_vld;
  assign lifo_waddr      = lifo_done ? last : rd_vld_idx; // done carries last index
  assign lifo_wdata.dbit = trel_state[cSTATE_W-1];        // newest input bit
  assign lifo_wdata.unc  = rd_data.unc;

  //----------------------------------------------------------
  // walk FSM
  //----------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state      <= st_idle;
      rd_vld     <= 1'b0;
      lifo_done  <= 1'b0;
      trel_state <= '0;
    end
    else begin
      rd_vld    <= (state == st_walk);
      lifo_done <= rd_vld & (rd_vld_idx == '0);
      case (state)
        st_idle : begin
          if (job_valid && job_ready) begin
            state      <= st_walk;
            trel_state <= '0; // tail bits force state 0
          end
        end
        st_walk : begin
          if (rd_idx == '0) begin
            state <= st_drain;
          end
        end
        st_drain : begin
          if (lifo_done) begin
            state <= st_idle; // lifo_free already low by now
          end
        end
        default : state <= st_idle;
      endcase
      if (rd_vld) begin
        trel_state <= trb_prev_state(trel_state, rd_data.decision);
      end
    end
  end

  // address counters
  always_ff @(posedge iclk) begin
    rd_vld_idx <= rd_idx;
    if (state == st_idle) begin
      bank   <= job.bank;
      last   <= job.last;
      rd_idx <= job.last; // start at the tail
    end
    else if (state == st_walk) begin
      rd_idx <= rd_idx - 1'b1;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // a waiting job stays put until it is taken
  a_job_hold : assert property (@(posedge iclk) disable iff (ireset)
    (job_valid && !job_ready) |=> (job_valid && $stable(job)));

endmodule

// ==== hdl/vit_trb_lifo.sv ====
module vit_trb_lifo import vit_trb_pkg::*; (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                lifo_wr,
  input  logic [cFRAME_W-1:0] lifo_waddr,
  input  trb_lifo_word_t      lifo_wdata,
  input  logic                lifo_done,
  output logic                lifo_free,
  output trb_out_t            out_step,
  output logic                out_valid,
  input  logic                out_ready
);

  trb_lifo_word_t      mem [cFRAME_MAX];
  logic [cFRAME_W-1:0] last;   // final index of the frame
  logic [cFRAME_W-1:0] ptr;    // index on the output now
  logic [cFRAME_W-1:0] rd_idx;
  logic [cFRAME_W-1:0] end_idx;
  logic                xfer;
  logic                load;

  // written backward by index, replayed 0..last
  always_ff @(posedge iclk) begin
    if (lifo_wr) begin
      mem[lifo_waddr] <= lifo_wdata;
    end
  end

  //----------------------------------------------------------
  // replay
  //----------------------------------------------------------

  assign xfer      = out_valid & out_ready;
  assign load      = lifo_done | (xfer & ~out_step.eop); // fetch next word
  assign rd_idx    = lifo_done ? '0 : ptr + 1'b1;
  assign end_idx   = lifo_done ? lifo_waddr : last;
  assign lifo_free = ~out_valid; // busy for the whole replay

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_valid <= 1'b0;
      ptr       <= '0;
      last      <= '0;
    end
    else begin
      if (lifo_done) begin
        out_valid <= 1'b1;
        ptr       <= '0;
        last      <= lifo_waddr;
      end
      else if (xfer) begin
        if (out_step.eop) begin
          out_valid <= 1'b0; // frame out
        end
        else begin
          ptr <= ptr + 1'b1;
        end
      end
    end
  end

  // output word, held while out_ready is low
  always_ff @(posedge iclk) begin
    if (load) begin
      out_step.sop  <= (rd_idx == '0);
      out_step.eop  <= (rd_idx == end_idx);
      out_step.dbit <= mem[rd_idx].dbit;
      out_step.unc  <= mem[rd_idx].unc;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // engine must wait for lifo_free
  a_no_wr_replay : assert property (@(posedge iclk) disable iff (ireset)
    lifo_wr |-> !out_valid);

endmodule

// ==== hdl/vit_trb_top.sv ====
module vit_trb_top import vit_trb_pkg::*; (
  input  logic      iclk,
  input  logic      ireset,
  input  trb_step_t in_step,
  input  logic      in_valid,
  output logic      in_ready,
  output trb_out_t  out_step,
  output logic      out_valid,
  input  logic      out_ready
);

  //----------------------------------------------------------
  // interconnect
  //----------------------------------------------------------

  // ctrl -> ram
  logic                   wr_en;
  logic [cRAM_ADDR_W-1:0] wr_addr;
  trb_ram_word_t          wr_data;
  // ctrl <-> engine
  trb_job_t               job;
  logic                   job_valid;
  logic                   job_ready;
  logic                   bank_free;
  // engine <-> ram
  logic [cRAM_ADDR_W-1:0] rd_addr;
  trb_ram_word_t          rd_data;
  // engine <-> lifo
  logic                   lifo_free;
  logic                   lifo_wr;
  logic [cFRAME_W-1:0]    lifo_waddr;
  trb_lifo_word_t         lifo_wdata;
  logic                   lifo_done;

  //----------------------------------------------------------
  // blocks
  //----------------------------------------------------------

  vit_trb_ctrl u_ctrl (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_step   (in_step),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .job       (job),
    .job_valid (job_valid),
    .job_ready (job_ready),
    .bank_free (bank_free)
  );

  vit_trb_ram u_ram (
    .iclk    (iclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  vit_trb_engine u_engine (
    .iclk       (iclk),
    .ireset     (ireset),
    .job        (job),
    .job_valid  (job_valid),
    .job_ready  (job_ready),
    .bank_free  (bank_free),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .lifo_free  (lifo_free),
    .lifo_wr    (lifo_wr),
    .lifo_waddr (lifo_waddr),
    .lifo_wdata (lifo_wdata),
    .lifo_done  (lifo_done)
  );

  vit_trb_lifo u_lifo (
    .iclk       (iclk),
    .ireset     (ireset),
    .lifo_wr    (lifo_wr),
    .lifo_waddr (lifo_waddr),
    .lifo_wdata (lifo_wdata),
    .lifo_done  (lifo_done),
    .lifo_free  (lifo_free),
    .out_step   (out_step),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

// ==== sim/vit_trb_checker.sv ====
module vit_trb_checker import vit_trb_pkg::*; (
  input  logic     iclk,
  input  logic     ireset,
  input  trb_out_t out_step,
  input  logic     out_valid,
  input  logic     out_ready
);

  trb_out_t exp_q [$];    // expected output steps, oldest first
  trb_out_t exp_word;
  int       test_steps   = 0;
  int       test_errs    = 0;
  int       steps_total  = 0;
  int       err_total    = 0;
  int       tests_run    = 0;
  int       tests_failed = 0;

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic push_expected(input trb_out_t w);
    exp_q.push_back(w);
  endtask

  task automatic compare_field(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      test_errs++;
    end
  endtask

  // plain failure, stale expectations dropped
  task automatic note_failure(input string what);
    $display("error at %0t: %s", $time, what);
    test_errs++;
    exp_q.delete();
  endtask

  //----------------------------------------------------------
  // output monitor
  //----------------------------------------------------------

  always @(posedge iclk) begin
    if (!ireset && out_valid && out_ready) begin // one transfer
      if (exp_q.size() == 0) begin
        $display("error at %0t: output step with nothing expected", $time);
        test_errs++;
      end
      else begin
        exp_word = exp_q.pop_front();
        compare_field("out_step.sop", out_step.sop, exp_word.sop);
        compare_field("out_step.eop", out_step.eop, exp_word.eop);
        compare_field("out_step.dbit", out_step.dbit, exp_word.dbit);
        compare_field("out_step.unc", out_step.unc, exp_word.unc);
        test_steps++;
      end
    end
  end

  task automatic end_test(input int t, input int nfrm, input int len);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    steps_total += test_steps;
    err_total   += test_errs;
    $display("test %0d (%0d x %0d steps): %0d steps checked, %0d errors, %s",
             t, nfrm, len, test_steps, test_errs, (test_errs == 0) ? "ok" : "FAILED");
    test_steps = 0;
    test_errs  = 0;
  endtask

endmodule

// ==== sim/vit_trb_tb.sv ====
module vit_trb_tb import vit_trb_pkg::*; ();

  localparam int cTEST_NUM  = 7;
  localparam int cREADY_MAX = 2000; // cycles to wait for in_ready
  localparam int cDRAIN_MAX = 8000; // cycles to wait for a test's output

  // one table row, several equal frames
  typedef struct packed {
    int nfrm;  // frames in the test
    int len;   // steps per frame, tail included
    int gap;   // idle cycles after each frame
    int stall; // chance of out_ready low, percent
  } test_t;

  logic        iclk;
  logic        ireset;
  trb_step_t   in_step;
  logic        in_valid;
  logic        in_ready;
  trb_out_t    out_step;
  logic        out_valid;
  logic        out_ready;

  test_t       tests [cTEST_NUM];
  logic [31:0] data_seed;   // info bits, unc, decision noise
  logic [31:0] stall_seed;  // out_ready pattern
  int          stall_pct = 0;
  trb_step_t   frame_q [$]; // steps of the frame being sent

  //----------------------------------------------------------
  // DUT and checker
  //----------------------------------------------------------

  vit_trb_top u_vit_trb_top (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_step   (in_step),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_step  (out_step),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  vit_trb_checker u_checker (
    .iclk      (iclk),
    .ireset    (ireset),
    .out_step  (out_step),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // 32-bit lcg, upper bits used
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;
  end

  // out_ready redrawn every cycle
  initial begin
    out_ready  = 1'b1;
    stall_seed = lcg_next(32'd40568);
    forever begin
      @(posedge iclk);
      #2;
      stall_seed = lcg_next(stall_seed);
      out_ready  = (int'(stall_seed[31:16]) % 100) >= stall_pct;
    end
  end

  //----------------------------------------------------------
  // encoder model
  //----------------------------------------------------------

  // state = last three info bits, newest in the msb
  // true decision is the bit pushed out of the register
  task automatic build_frame(input int len);
    logic [cSTATE_W-1:0]   st;
    logic [cSTATE_W-1:0]   nxt;
    logic [cSTATE_NUM-1:0] dec;
    logic                  b;
    logic [cUNC_W-1:0]     u;
    trb_step_t             s;
    trb_out_t              e;
    int                    k;
    st = '0;
    frame_q.delete();
    for (k = 0; k < len; k++) begin
      data_seed = lcg_next(data_seed);
      b         = (k < len - 3) ? data_seed[31] : 1'b0; // tail forces state 0
      u         = data_seed[30:29];
      data_seed = lcg_next(data_seed);
      dec       = data_seed[31:24]; // noise on the wrong states
      nxt       = {b, st[cSTATE_W-1:1]};
      dec[nxt]  = st[0];
      s.sop      = (k == 0);
      s.eop      = (k == len - 1);
      s.decision = dec;
      s.unc      = u;
      frame_q.push_back(s);
      e.sop  = (k == 0);
      e.eop  = (k == len - 1);
      e.dbit = b;
      e.unc  = u;
      u_checker.push_expected(e);
      st = nxt;
    end
  endtask

  // in_ready moves only on edges, so it is stable here
  task automatic send_step(input trb_step_t s);
    int cnt;
    in_step  = s;
    in_valid = 1'b1;
    cnt      = 0;
    while (!in_ready && cnt < cREADY_MAX) begin
      @(posedge iclk);
      #2;
      cnt++;
    end
    if (!in_ready) begin
      u_checker.note_failure("in_ready stayed low, an input step was never accepted");
    end
    @(posedge iclk); // transfer edge
    #2;
    in_valid = 1'b0;
  endtask

  task automatic run_test(input int t);
    int f;
    int g;
    int cnt;
    stall_pct = tests[t].stall;
    for (f = 0; f < tests[t].nfrm; f++) begin
      build_frame(tests[t].len);
      while (frame_q.size() > 0) begin
        send_step(frame_q.pop_front());
      end
      for (g = 0; g < tests[t].gap; g++) begin
        @(posedge iclk);
        #2;
      end
    end
    // wait for the last frame to come out
    cnt = 0;
    while (u_checker.pending() != 0 && cnt < cDRAIN_MAX) begin
      @(posedge iclk);
      #2;
      cnt++;
    end
    if (u_checker.pending() != 0) begin
      u_checker.note_failure("output frames did not finish before the timeout");
    end
    u_checker.end_test(t, tests[t].nfrm, tests[t].len);
  endtask

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------

  initial begin
    ireset    = 1'b1;
    in_step   = '0;
    in_valid  = 1'b0;
    data_seed = 32'd40568;
    tests[0]  = '{1, 16, 0, 0};  // single frame
    tests[1]  = '{1, 4, 3, 0};   // shortest
    tests[2]  = '{1, 64, 3, 0};  // longest
    tests[3]  = '{4, 24, 0, 0};  // back to back
    tests[4]  = '{3, 64, 0, 0};
    tests[5]  = '{5, 12, 2, 30}; // output stalls
    tests[6]  = '{4, 40, 0, 60}; // stalls push back to in_ready
    repeat (10) @(posedge iclk);
    #2;
    ireset = 1'b0;
    if (!in_ready) begin
      u_checker.note_failure("in_ready is low after reset");
    end
    for (int t = 0; t < cTEST_NUM; t++) begin
      run_test(t);
    end
    $display("summary: %0d tests, %0d failed, %0d steps checked, %0d errors",
             u_checker.tests_run, u_checker.tests_failed,
             u_checker.steps_total, u_checker.err_total);
    if (u_checker.tests_failed == 0 && u_checker.err_total == 0) begin
      $display("All tests passed");
    end
    else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== vit_trb.f ====
hdl/vit_trb_pkg.sv
hdl/vit_trb_ram.sv
hdl/vit_trb_ctrl.sv
hdl/vit_trb_engine.sv
hdl/vit_trb_lifo.sv
hdl/vit_trb_top.sv
sim/vit_trb_checker.sv
sim/vit_trb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the traceback testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module vit_trb_tb -f vit_trb.f \
  -Mdir obj_dir -o vit_trb_sim \
  && ./obj_dir/vit_trb_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -q "^All tests passed$" sim.log && echo "RESULT: PASS" && exit 0 \
  || { echo "RESULT: FAIL"; exit 1; }
